//--- source/tcp_pkg.sv
package tcp_pkg;

  ////////////////////
  // constants
  ////////////////////
  localparam logic [31:0] LOC_ISN            = 32'hfeadabba;
  localparam int          ACK_TIMEOUT_TICKS  = 64;
  localparam int          CONN_TIMEOUT_TICKS = 400;
  localparam int          ACK_TMR_W          = $clog2(ACK_TIMEOUT_TICKS + 1);
  localparam int          CONN_TMR_W         = $clog2(CONN_TIMEOUT_TICKS + 1);

  localparam int          IP_HDR_BYTES  = 20;
  localparam int          TCP_HDR_BYTES = 20;
  localparam int          SYN_HDR_BYTES = 28; // tcp header plus options space
  localparam logic [15:0] WIN_SIZE      = 16'd10;

  localparam logic [8:0] FLAGS_SYN_ACK = 9'h012;
  localparam logic [8:0] FLAGS_ACK     = 9'h010;
  localparam logic [8:0] FLAGS_PSH_ACK = 9'h018;
  localparam logic [8:0] FLAGS_FIN_ACK = 9'h011;

  ////////////////////
  // flags word
  ////////////////////
  typedef struct packed {
    logic ns;
    logic cwr;
    logic ece;
    logic urg;
    logic ack;
    logic psh;
    logic rst;
    logic syn;
    logic fin;
  } tcp_flag_bits_t;

  // raw view for whole-word codes, bits view for single flag tests
  typedef union packed {
    logic [8:0]     raw;
    tcp_flag_bits_t bits;
  } tcp_flags_u;

  ////////////////////
  // segment headers
  ////////////////////
  typedef struct packed {
    logic        hdr_v;
    logic [31:0] src_ip;
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [31:0] seq;
    logic [31:0] ack;
    tcp_flags_u  flags;
    logic [15:0] payload_len;
  } rx_seg_t;

  typedef struct packed {
    logic        hdr_v;
    logic [31:0] dst_ip;
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [31:0] seq;
    logic [31:0] ack;
    tcp_flags_u  flags;
    logic [15:0] win;
    logic [15:0] ip_len;
    logic [15:0] payload_len;
    logic [31:0] payload_cs;
  } tx_seg_t;

  typedef struct packed {
    logic        pend;
    logic [31:0] seq;
    logic [15:0] len;
    logic [31:0] cs;
  } queue_t;

  typedef struct packed {
    logic [31:0] rem_ip;
    logic [15:0] rem_port;
    logic [31:0] loc_seq;
    logic [31:0] loc_ack;
    logic [31:0] rem_seq;
    logic [31:0] rem_ack;
  } tcb_t;

  // seg.hdr_v doubles as the class valid pulse
  typedef struct packed {
    logic    syn_req;
    logic    hs_ack;
    logic    data_ok;
    logic    fin;
    logic    rst;
    logic    ack;
    rx_seg_t seg;
  } seg_class_t;

  typedef enum logic [2:0] {
    tx_none,
    tx_syn_ack,
    tx_data,
    tx_bare_ack,
    tx_fin_ack,
    tx_last_ack  // ack of the remote fin
  } tx_kind_e;

  typedef enum logic [2:0] {
    st_closed,
    st_listen,
    st_syn_received,
    st_established,
    st_close_ack,
    st_last_ack
  } conn_state_e;

endpackage

//--- source/tcp_rx_filter.sv
`timescale 1ns/1ps

module tcp_rx_filter import tcp_pkg::*; (
  input  logic        clk,
  input  logic        tcp_rst,
  input  logic [15:0] local_port,
  input  tcb_t        tcb,
  input  conn_state_e state,
  input  rx_seg_t     rx_seg,
  input  logic        rx_v,
  input  logic [7:0]  rx_d,
  output seg_class_t  seg_class,
  output logic        vout,
  output logic [7:0]  dout
);

  rx_seg_t    rx_q;
  logic       rx_v_q;
  logic [7:0] rx_d_q;
  logic       port_ok;
  logic       pair_ok;
  logic       gate;
  seg_class_t cls;

  // input stage
  always_ff @(posedge clk) begin
    if (tcp_rst) begin
      rx_q.hdr_v <= 1'b0;
      rx_v_q     <= 1'b0;
    end else begin
      rx_q   <= rx_seg;
      rx_v_q <= rx_v;
    end
    rx_d_q <= rx_d;
  end

  assign port_ok = (rx_q.dst_port == local_port);
  assign pair_ok = port_ok && (rx_q.src_port == tcb.rem_port);

  always_comb begin
    cls         = '0;
    cls.seg     = rx_q;
    cls.syn_req = rx_q.hdr_v && rx_q.flags.bits.syn && port_ok;
    cls.hs_ack  = rx_q.hdr_v && rx_q.flags.bits.ack && pair_ok &&
                  (rx_q.seq == tcb.rem_seq + 32'd1);
    cls.data_ok = rx_q.hdr_v && pair_ok && (rx_q.seq == tcb.loc_ack) &&
                  (state == st_established); // in-order only
    cls.fin     = rx_q.hdr_v && pair_ok && rx_q.flags.bits.fin;
    cls.rst     = rx_q.hdr_v && pair_ok && rx_q.flags.bits.rst;
    cls.ack     = rx_q.hdr_v && pair_ok && rx_q.flags.bits.ack;
  end

  ////////////////////
  // class and byte gate
  ////////////////////
  always_ff @(posedge clk) begin
    if (tcp_rst) begin
      seg_class <= '0;
      gate      <= 1'b0;
      vout      <= 1'b0;
    end else begin
      seg_class <= cls;
      if (cls.data_ok) begin
        gate <= 1'b1;
      end else if (rx_q.hdr_v || state != st_established || (vout && !rx_v_q)) begin
        gate <= 1'b0; // other header, lost state or end of payload
      end
      vout <= rx_v_q && gate;
    end
    dout <= rx_d_q;
  end

endmodule

//--- source/tcp_timers.sv
`timescale 1ns/1ps

module tcp_timers import tcp_pkg::*; (
  input  logic        clk,
  input  logic        tcp_rst,
  input  conn_state_e state,
  input  logic        data_ok,
  input  logic        data_nonzero,
  output logic        ack_due,
  output logic        conn_expired
);

  logic [ACK_TMR_W-1:0]  ack_tmr;
  logic [CONN_TMR_W-1:0] conn_tmr;
  logic                  hs_or_close;

  // delayed ack, parked at the top value until data arrives
  always_ff @(posedge clk) begin
    if (tcp_rst || state != st_established) begin
      ack_tmr <= ACK_TMR_W'(ACK_TIMEOUT_TICKS);
      ack_due <= 1'b0;
    end else if (data_ok && data_nonzero) begin
      ack_tmr <= '0;
      ack_due <= 1'b0;
    end else if (ack_tmr != ACK_TMR_W'(ACK_TIMEOUT_TICKS)) begin
      ack_tmr <= ack_tmr + 1'b1;
      ack_due <= (ack_tmr == ACK_TMR_W'(ACK_TIMEOUT_TICKS - 1)); // once per segment
    end else begin
      ack_due <= 1'b0;
    end
  end

  assign hs_or_close = !(state inside {st_closed, st_listen, st_established});

  // handshake and closing watchdog
  always_ff @(posedge clk) begin
    if (tcp_rst || !hs_or_close) begin
      conn_tmr     <= '0;
      conn_expired <= 1'b0;
    end else begin
      conn_tmr     <= conn_tmr + 1'b1;
      conn_expired <= (conn_tmr == CONN_TMR_W'(CONN_TIMEOUT_TICKS - 1));
    end
  end

endmodule

//--- source/tcp_conn_fsm.sv
`timescale 1ns/1ps

module tcp_conn_fsm import tcp_pkg::*; (
  input  logic        clk,
  input  logic        tcp_rst,
  input  logic        listen,
  input  seg_class_t  seg_class,
  input  queue_t      queue,
  input  logic        ack_due,
  input  logic        conn_expired,
  input  logic        busy_hold,
  output conn_state_e state,
  output tcb_t        tcb,
  output tx_kind_e    tx_req,
  output queue_t      tx_queue,
  output logic        connected
);

  rx_seg_t hdr;
  logic    req_ok;
  logic    ack_owed;   // forced ack waiting for a free slot
  logic    close_sent; // ack of remote fin already requested

  assign hdr    = seg_class.seg;
  assign req_ok = !busy_hold;

  always_ff @(posedge clk) begin
    if (tcp_rst) begin
      state      <= st_closed;
      tcb        <= '0;
      tx_req     <= tx_none;
      connected  <= 1'b0;
      ack_owed   <= 1'b0;
      close_sent <= 1'b0;
    end else begin
      tx_req <= tx_none;
      if (ack_due && state == st_established) ack_owed <= 1'b1;

      if (conn_expired) begin
        state     <= st_closed;
        tcb       <= '0;
        connected <= 1'b0;
        ack_owed  <= 1'b0;
      end else begin
        case (state)
          st_closed: begin
            if (listen) state <= st_listen;
          end

          st_listen: begin
            if (seg_class.syn_req && req_ok) begin // new tcb for the remote side
              state        <= st_syn_received;
              tcb.rem_ip   <= hdr.src_ip;
              tcb.rem_port <= hdr.src_port;
              tcb.loc_seq  <= LOC_ISN;
              tcb.loc_ack  <= hdr.seq + 32'd1;
              tcb.rem_seq  <= hdr.seq;
              tcb.rem_ack  <= hdr.ack;
              tx_req       <= tx_syn_ack;
            end
          end

          st_syn_received: begin
            if (seg_class.hs_ack) begin
              state       <= st_established;
              connected   <= 1'b1;
              tcb.loc_seq <= hdr.ack;
              tcb.rem_seq <= hdr.seq;
              tcb.rem_ack <= hdr.ack;
            end
          end

          ////////////////////
          // data phase
          ////////////////////
          st_established: begin
            if (seg_class.data_ok) begin
              tcb.loc_ack <= tcb.loc_ack + 32'(hdr.payload_len);
              tcb.rem_seq <= hdr.seq;
              tcb.rem_ack <= hdr.ack;
            end
            if (seg_class.rst) begin
              state     <= st_closed;
              tcb       <= '0; // overrides the update above
              connected <= 1'b0;
              ack_owed  <= 1'b0;
            end else if (seg_class.fin) begin
              state    <= st_close_ack;
              ack_owed <= 1'b0;
              if (req_ok) begin
                tx_req     <= tx_last_ack;
                close_sent <= 1'b1;
              end else begin
                close_sent <= 1'b0;
              end
            end else if (queue.pend && req_ok) begin
              tx_req      <= tx_data;
              tx_queue    <= queue;
              tcb.loc_seq <= queue.seq + 32'(queue.len);
              ack_owed    <= 1'b0; // data header carries the ack
            end else if (ack_owed && req_ok) begin
              tx_req   <= tx_bare_ack;
              ack_owed <= 1'b0;
            end
          end

          ////////////////////
          // passive close
          ////////////////////
          st_close_ack: begin
            if (req_ok) begin
              if (close_sent) begin
                tx_req <= tx_fin_ack;
                state  <= st_last_ack;
              end else begin
                tx_req     <= tx_last_ack;
                close_sent <= 1'b1;
              end
            end
          end

          st_last_ack: begin
            if (seg_class.ack) begin
              state     <= st_closed;
              tcb       <= '0;
              connected <= 1'b0;
            end
          end

          default: state <= st_closed;
        endcase
      end
    end
  end

endmodule

//--- source/tcp_tx_hdr.sv
`timescale 1ns/1ps

module tcp_tx_hdr import tcp_pkg::*; (
  input  logic        clk,
  input  logic        tcp_rst,
  input  logic [15:0] local_port,
  input  tx_kind_e    tx_req,
  input  tcb_t        tcb,
  input  queue_t      tx_queue,
  input  logic        tx_busy,
  output tx_seg_t     tx_seg,
  output logic        busy_hold
);

  tx_seg_t built;
  tx_seg_t hold_q;
  logic    pend_q;

  function automatic tx_seg_t build_hdr(tx_kind_e kind, tcb_t t, queue_t q,
                                        logic [15:0] port);
    tx_seg_t s;
    s             = '0;
    s.hdr_v       = 1'b1;
    s.dst_ip      = t.rem_ip;
    s.src_port    = port;
    s.dst_port    = t.rem_port;
    s.seq         = t.loc_seq;
    s.ack         = t.loc_ack;
    s.flags.raw   = FLAGS_ACK;
    s.win         = WIN_SIZE;
    s.ip_len      = 16'(IP_HDR_BYTES + TCP_HDR_BYTES);
    case (kind)
      tx_syn_ack: begin
        s.flags.raw = FLAGS_SYN_ACK;
        s.ip_len    = 16'(IP_HDR_BYTES + SYN_HDR_BYTES);
      end
      tx_data: begin
        s.flags.raw   = FLAGS_PSH_ACK;
        s.seq         = q.seq;
        s.ip_len      = 16'(IP_HDR_BYTES + TCP_HDR_BYTES) + q.len;
        s.payload_len = q.len;
        s.payload_cs  = q.cs;
      end
      tx_last_ack: s.ack = t.loc_ack + 32'd1; // fin takes one sequence number
      tx_fin_ack: begin
        s.flags.raw = FLAGS_FIN_ACK;
        s.ack       = t.loc_ack + 32'd1;
      end
      default: ; // bare ack keeps the defaults
    endcase
    return s;
  endfunction

  assign built = build_hdr(tx_req, tcb, tx_queue, local_port);

  // a request and a held header never meet, the fsm waits on busy_hold
  assign busy_hold = pend_q || (tx_req != tx_none);

  always_ff @(posedge clk) begin
    if (tcp_rst) begin
      tx_seg.hdr_v <= 1'b0;
      pend_q       <= 1'b0;
    end else if (tx_req != tx_none) begin
      if (tx_busy) begin
        hold_q       <= built;
        pend_q       <= 1'b1;
        tx_seg.hdr_v <= 1'b0;
      end else begin
        tx_seg <= built;
      end
    end else if (pend_q && !tx_busy) begin
      tx_seg <= hold_q; // release the held header
      pend_q <= 1'b0;
    end else begin
      tx_seg.hdr_v <= 1'b0;
    end
  end

endmodule

//--- source/tcp_conn_top.sv
`timescale 1ns/1ps

module tcp_conn_top import tcp_pkg::*; (
  input  logic        clk,
  input  logic        tcp_rst,
  input  logic        listen,
  input  logic [15:0] local_port,
  input  rx_seg_t     rx_seg,
  input  logic        rx_v,
  input  logic [7:0]  rx_d,
  input  queue_t      queue,
  input  logic        tx_busy,
  output tx_seg_t     tx_seg,
  output logic        vout,
  output logic [7:0]  dout,
  output logic        connected
);

  tcb_t        tcb;
  conn_state_e state;
  seg_class_t  seg_class;
  tx_kind_e    tx_req;
  queue_t      tx_queue;
  logic        ack_due;
  logic        conn_expired;
  logic        busy_hold;

  tcp_rx_filter rx_filter0 (
    .clk        (clk),
    .tcp_rst    (tcp_rst),
    .local_port (local_port),
    .tcb        (tcb),
    .state      (state),
    .rx_seg     (rx_seg),
    .rx_v       (rx_v),
    .rx_d       (rx_d),
    .seg_class  (seg_class),
    .vout       (vout),
    .dout       (dout)
  );

  tcp_timers timers0 (
    .clk          (clk),
    .tcp_rst      (tcp_rst),
    .state        (state),
    .data_ok      (seg_class.data_ok),
    .data_nonzero (seg_class.seg.payload_len != 16'd0),
    .ack_due      (ack_due),
    .conn_expired (conn_expired)
  );

  tcp_conn_fsm conn_fsm0 (
    .clk          (clk),
    .tcp_rst      (tcp_rst),
    .listen       (listen),
    .seg_class    (seg_class),
    .queue        (queue),
    .ack_due      (ack_due),
    .conn_expired (conn_expired),
    .busy_hold    (busy_hold),
    .state        (state),
    .tcb          (tcb),
    .tx_req       (tx_req),
    .tx_queue     (tx_queue),
    .connected    (connected)
  );

  tcp_tx_hdr tx_hdr0 (
    .clk        (clk),
    .tcp_rst    (tcp_rst),
    .local_port (local_port),
    .tx_req     (tx_req),
    .tcb        (tcb),
    .tx_queue   (tx_queue),
    .tx_busy    (tx_busy),
    .tx_seg     (tx_seg),
    .busy_hold  (busy_hold)
  );

endmodule

//--- test/tcp_conn_asserts.sv
`timescale 1ns/1ps

module tcp_conn_asserts import tcp_pkg::*; (
  input logic    clk,
  input logic    tcp_rst,
  input logic    tx_busy,
  input tx_seg_t tx_seg,
  input logic    vout,
  input logic    connected
);

  int fail_cnt = 0; // read by the testbench

  // a header only leaves from an edge where the transmitter was free
  no_hdr_while_busy: assert property (
    @(posedge clk) disable iff (tcp_rst) tx_seg.hdr_v |-> !$past(tx_busy))
    else begin
      $error("segment header left while tx_busy was high");
      fail_cnt++;
    end

  single_cycle_hdr: assert property (
    @(posedge clk) disable iff (tcp_rst) tx_seg.hdr_v |=> !tx_seg.hdr_v)
    else begin
      $error("header valid stayed high for two cycles");
      fail_cnt++;
    end

  quiet_after_reset: assert property (
    @(posedge clk) tcp_rst |=> !connected && !tx_seg.hdr_v && !vout)
    else begin
      $error("connected, vout or header valid high after reset");
      fail_cnt++;
    end

endmodule

bind tcp_conn_top tcp_conn_asserts asserts0 (
  .clk       (clk),
  .tcp_rst   (tcp_rst),
  .tx_busy   (tx_busy),
  .tx_seg    (tx_seg),
  .vout      (vout),
  .connected (connected)
);

//--- test/tb_tcp_conn.sv
`timescale 1ns/1ps

module tb_tcp_conn import tcp_pkg::*; ();

  localparam int          CYCLE_LIMIT = 6000;
  localparam int          HDR_WAIT    = 200;
  localparam logic [15:0] LOCAL_PORT  = 16'h1f90;
  localparam logic [15:0] REM_PORT    = 16'hd431;
  localparam logic [31:0] REM_IP      = 32'hc0a80107;
  localparam logic [8:0]  FLAG_SYN    = 9'h002;
  localparam logic [8:0]  FLAG_RST    = 9'h004;

  logic        clk;
  logic        tcp_rst;
  logic        listen;
  logic [15:0] local_port;
  rx_seg_t     rx_seg;
  logic        rx_v;
  logic [7:0]  rx_d;
  queue_t      queue;
  logic        tx_busy;
  tx_seg_t     tx_seg;
  logic        vout;
  logic [7:0]  dout;
  logic        connected;

  int          cycles = 0;
  logic [31:0] rng = 32'hc1ea;
  logic [31:0] rem_isn;
  logic [31:0] loc_seq; // reference tcb
  logic [31:0] loc_ack;
  logic [7:0]  exp_bytes[$];
  logic [7:0]  got_bytes[$];

  tcp_conn_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_mismatch(input string what);
    stop_run($sformatf("mismatch at %0t ns: %s", $time, what));
  endtask

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
  endtask

  task automatic check_hdr(input string tag, input tx_seg_t h, input logic [8:0] flags,
                           input logic [31:0] seq, input logic [31:0] ack,
                           input logic [15:0] ip_len);
    check_eq({tag, " flags"}, h.flags.raw, flags);
    check_eq({tag, " seq"}, h.seq, seq);
    check_eq({tag, " ack"}, h.ack, ack);
    check_eq({tag, " ip_len"}, h.ip_len, ip_len);
    check_eq({tag, " dst_ip"}, h.dst_ip, REM_IP);
    check_eq({tag, " dst_port"}, h.dst_port, REM_PORT);
    check_eq({tag, " src_port"}, h.src_port, LOCAL_PORT);
    check_eq({tag, " win"}, h.win, WIN_SIZE);
  endtask

  ////////////////////
  // remote peer
  ////////////////////
  task automatic send_seg(input logic [8:0] flags, input logic [31:0] seq,
                          input logic [31:0] ack, input logic [15:0] len);
    rx_seg_t s;
    s             = '0;
    s.hdr_v       = 1'b1;
    s.src_ip      = REM_IP;
    s.src_port    = REM_PORT;
    s.dst_port    = LOCAL_PORT;
    s.seq         = seq;
    s.ack         = ack;
    s.flags.raw   = flags;
    s.payload_len = len;
    rx_seg        = s;
    @(negedge clk);
    rx_seg.hdr_v = 1'b0; // one-cycle header pulse
  endtask

  task automatic send_bytes(input int n, input bit in_order);
    for (int i = 0; i < n; i++) begin
      rng  = xorshift(rng);
      rx_v = 1'b1;
      rx_d = rng[7:0];
      if (in_order) exp_bytes.push_back(rng[7:0]);
      @(negedge clk);
    end
    rx_v = 1'b0;
  endtask

  task automatic wait_hdr(output tx_seg_t h, output int lat);
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!tx_seg.hdr_v && lat < HDR_WAIT);
    assert (tx_seg.hdr_v) else stop_run("no segment header came out in time");
    h = tx_seg;
  endtask

  task automatic expect_quiet(input int n);
    repeat (n) begin
      @(negedge clk);
      assert (!tx_seg.hdr_v) else stop_run("a segment header came out when none was due");
    end
  endtask

  task automatic wait_connected(input logic lvl);
    int n;
    n = 0;
    while (connected !== lvl && n < 20) begin
      @(negedge clk);
      n++;
    end
    assert (connected === lvl)
      else stop_run($sformatf("connected did not settle at %0b", lvl));
  endtask

  task automatic offer_syn();
    tx_seg_t h;
    int      lat;
    rng     = xorshift(rng);
    rem_isn = rng;
    send_seg(FLAG_SYN, rem_isn, 32'd0, 16'd0);
    wait_hdr(h, lat);
    check_eq("syn-ack latency", lat, 3);
    check_hdr("syn-ack", h, FLAGS_SYN_ACK, LOC_ISN, rem_isn + 32'd1, 16'd48);
  endtask

  task automatic open_conn();
    offer_syn();
    loc_seq = LOC_ISN + 32'd1;
    loc_ack = rem_isn + 32'd1;
    send_seg(FLAGS_ACK, loc_ack, loc_seq, 16'd0);
    wait_connected(1'b1);
  endtask

  // gap of zero means no back-pressure
  task automatic queue_data(input int gap);
    queue_t  q;
    tx_seg_t h;
    int      lat;
    rng    = xorshift(rng);
    q.pend = 1'b1;
    q.seq  = loc_seq;
    q.len  = 16'd16 + 16'(rng[11:4]);
    q.cs   = xorshift(rng);
    tx_busy = (gap > 0);
    queue   = q;
    if (gap > 0) begin
      expect_quiet(gap);
      tx_busy = 1'b0;
    end
    wait_hdr(h, lat);
    queue.pend = 1'b0; // header taken
    if (gap == 0) check_eq("data latency", lat, 2);
    check_hdr("data", h, FLAGS_PSH_ACK, q.seq, loc_ack, 16'd40 + q.len);
    check_eq("data payload_len", h.payload_len, q.len);
    check_eq("data payload_cs", h.payload_cs, q.cs);
    loc_seq = q.seq + 32'(q.len);
  endtask

  // received bytes and bound assertion failures
  always @(negedge clk) begin
    if (vout) got_bytes.push_back(dout);
    if (dut0.asserts0.fail_cnt != 0) stop_run("a protocol assertion on the DUT failed");
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT)
      stop_run($sformatf("timeout: test did not finish within %0d cycles", CYCLE_LIMIT));
  end

  initial begin
    tx_seg_t h;
    int      lat;
    int      t_data;
    tcp_rst    = 1'b1;
    listen     = 1'b0;
    local_port = LOCAL_PORT;
    rx_seg     = '0;
    rx_v       = 1'b0;
    rx_d       = 8'h00;
    queue      = '0;
    tx_busy    = 1'b0;
    repeat (3) @(negedge clk);
    tcp_rst = 1'b0;
    listen  = 1'b1;
    repeat (2) @(negedge clk);

    open_conn();

    ////////////////////
    // receive path
    ////////////////////
    send_seg(FLAGS_PSH_ACK, loc_ack, loc_seq, 16'd5);
    t_data = cycles;
    send_bytes(5, 1'b1);
    expect_quiet(4);
    check_eq("received byte count", got_bytes.size(), 5);
    foreach (exp_bytes[i]) check_eq("received byte", got_bytes[i], exp_bytes[i]);
    loc_ack = loc_ack + 32'd5;
    send_seg(FLAGS_PSH_ACK, loc_ack + 32'd100, loc_seq, 16'd4); // out of order
    send_bytes(4, 1'b0);
    expect_quiet(4);
    check_eq("byte count after out-of-order segment", got_bytes.size(), 5);

    // exactly one delayed ack
    wait_hdr(h, lat);
    check_hdr("delayed ack", h, FLAGS_ACK, loc_seq, loc_ack, 16'd40);
    assert (cycles - t_data >= ACK_TIMEOUT_TICKS)
      else stop_run("delayed ack came before the ack timeout");
    expect_quiet(ACK_TIMEOUT_TICKS + 8);

    ////////////////////
    // transmit path
    ////////////////////
    rng = xorshift(rng);
    queue_data(2 + int'(rng[2:0]));
    queue_data(0);

    // passive close
    send_seg(FLAGS_FIN_ACK, loc_ack, loc_seq, 16'd0);
    wait_hdr(h, lat);
    check_hdr("ack of fin", h, FLAGS_ACK, loc_seq, loc_ack + 32'd1, 16'd40);
    wait_hdr(h, lat);
    check_hdr("fin-ack", h, FLAGS_FIN_ACK, loc_seq, loc_ack + 32'd1, 16'd40);
    send_seg(FLAGS_ACK, loc_ack + 32'd1, loc_seq + 32'd1, 16'd0);
    wait_connected(1'b0);

    ////////////////////
    // reset paths
    ////////////////////
    repeat (2) @(negedge clk);
    open_conn();
    send_seg(FLAG_RST, loc_ack, loc_seq, 16'd0);
    expect_quiet(8); // rst gets no answer
    check_eq("connected after rst", connected, 1'b0);

    repeat (2) @(negedge clk);
    offer_syn(); // left half open
    expect_quiet(CONN_TIMEOUT_TICKS - 40);
    send_seg(FLAG_SYN, rem_isn, 32'd0, 16'd0); // retransmitted syn before the timeout
    expect_quiet(48);
    open_conn();
    repeat (4) @(negedge clk);

    if (dut0.asserts0.fail_cnt != 0) begin
      stop_run("a protocol assertion on the DUT failed");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

//--- flist.f
source/tcp_pkg.sv
source/tcp_rx_filter.sv
source/tcp_timers.sv
source/tcp_conn_fsm.sv
source/tcp_tx_hdr.sv
source/tcp_conn_top.sv
test/tcp_conn_asserts.sv
test/tb_tcp_conn.sv

//--- Bender.yml
package:
  name: tcp_conn

sources:
  - source/tcp_pkg.sv
  - source/tcp_rx_filter.sv
  - source/tcp_timers.sv
  - source/tcp_conn_fsm.sv
  - source/tcp_tx_hdr.sv
  - source/tcp_conn_top.sv
  - target: test
    files:
      - test/tcp_conn_asserts.sv
      - test/tb_tcp_conn.sv
